// ==== design/aes_macros.svh ====
`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

// Rounds of AES-128
`define AES_NR 10

// Test blocks sent per run
`define AES_NUM_VECTORS 11

// Cycles allowed in WAIT_KEY before the run is abandoned
`define AES_KEY_TIMEOUT 16

`endif

// ==== design/aes_pkg.sv ====
`include "aes_macros.svh"

package aes_pkg;

    typedef logic [127:0] aes_block_t;                      // One state or round key
    typedef logic [`AES_NR:0][127:0] aes_round_keys_t;      // Round keys 0..NR

    // ------------------------------
    // GF(2^8) arithmetic
    // ------------------------------
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);     // Multiply by x mod 0x11b
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i])
                p = p ^ x;
            x = xtime(x);
        end
        return p;
    endfunction

    // Inverse as a^254, zero maps to zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] r;
        logic [7:0] sq;
        r  = 8'h01;
        sq = a;
        for (int i = 1; i < 8; i++) begin
            sq = gf_mul(sq, sq);                             // a^(2^i)
            r  = gf_mul(r, sq);
        end
        return r;
    endfunction

    function automatic logic [7:0] rotl8(input logic [7:0] b, input int n);
        return (b << n) | (b >> (8 - n));
    endfunction

    // ------------------------------
    // S-boxes
    // ------------------------------
    function automatic logic [7:0] sbox(input logic [7:0] a);
        logic [7:0] v;
        v = gf_inv(a);
        return v ^ rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 3) ^ rotl8(v, 4) ^ 8'h63;
    endfunction

    function automatic logic [7:0] inv_sbox(input logic [7:0] b);
        return gf_inv(rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05);  // Undo affine first
    endfunction

    // ------------------------------
    // Whole-state round steps
    // ------------------------------
    function automatic aes_block_t sub_bytes(input aes_block_t s, input logic inv);
        aes_block_t o;
        for (int i = 0; i < 16; i++)
            o[8 * i +: 8] = inv ? inv_sbox(s[8 * i +: 8]) : sbox(s[8 * i +: 8]);
        return o;
    endfunction

    // Byte n = 4*col + row sits at bits 127-8n down
    function automatic aes_block_t shift_rows(input aes_block_t s, input logic inv);
        aes_block_t o;
        int src;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                src = inv ? 4 * ((c - r + 4) % 4) + r : 4 * ((c + r) % 4) + r;
                o[127 - 8 * (4 * c + r) -: 8] = s[127 - 8 * src -: 8];
            end
        end
        return o;
    endfunction

    function automatic aes_block_t mix_columns(input aes_block_t s, input logic inv);
        aes_block_t o;
        logic [3:0][7:0] m;
        logic [7:0] acc;
        m = inv ? 32'h0e0b0d09 : 32'h02030101;               // First matrix row
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                acc = 8'h00;
                for (int k = 0; k < 4; k++)
                    acc = acc ^ gf_mul(m[3 - k], s[127 - 8 * (4 * c + (r + k) % 4) -: 8]);
                o[127 - 8 * (4 * c + r) -: 8] = acc;
            end
        end
        return o;
    endfunction

endpackage

// ==== design/selftest_pkg.sv ====
package selftest_pkg;

    typedef logic [3:0] vec_idx_t;                          // Tag carried with each block

    typedef enum logic [2:0] {
        IDLE,
        KEY_GEN,                                             // One-cycle expander kick
        WAIT_KEY,
        FEED,
        HALT                                                 // Left only by reset
    } selftest_state_t;

    // FIPS-197 appendix C.1 key and matching ciphertext of vector 0
    localparam aes_pkg::aes_block_t SELFTEST_KEY   = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_pkg::aes_block_t KAT_CIPHERTEXT = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    function automatic aes_pkg::aes_block_t test_vector(input vec_idx_t idx);
        case (idx)
            4'd0:    return 128'h00112233445566778899aabbccddeeff;  // KAT plaintext
            4'd1:    return 128'h00112233445566000099aabbccddeeff;
            4'd2:    return 128'h66542233445566000099aabbccddeeff;
            4'd3:    return 128'h00000000000000000000000000000000;
            4'd4:    return 128'h11111111111111111111111111111111;
            4'd5:    return 128'h10101010101010101010101010101010;
            4'd6:    return 128'h01010101010101010101010101010101;
            4'd7:    return 128'h05050505050505050505050505050505;
            4'd8:    return 128'hffffffffffffffffffffffffffffffff;
            4'd9:    return 128'h33333333333333333333333333333333;
            4'd10:   return 128'hcccccccccccccccccccccccccccccccc;
            default: return '0;
        endcase
    endfunction

endpackage

// ==== design/aes_ifs.sv ====
`timescale 1ns/1ps

// Key load request and the resulting round key set
interface key_sched_if;
    import aes_pkg::*;

    logic            start;                                  // Pulse, clears ready
    aes_block_t      key;
    logic            ready;                                  // Keys stable while high
    aes_round_keys_t round_keys;

    modport ctrl     (output start, output key, input ready);
    modport expander (input start, input key, output ready, output round_keys);
    modport reader   (input ready, input round_keys);
endinterface

// Valid-only block stream, no back-pressure
interface block_stream_if;
    import aes_pkg::*;
    import selftest_pkg::*;

    logic       valid;
    aes_block_t data;
    vec_idx_t   tag;                                         // Vector index of this block
    logic       last;                                        // Final block of the run

    modport src (output valid, output data, output tag, output last);
    modport snk (input valid, input data, input tag, input last);
endinterface

// ==== design/aes_key_expand.sv ====
`timescale 1ns/1ps
`include "aes_macros.svh"

module aes_key_expand (
    input  logic          slow_clk,
    input  logic          rst_n,
    key_sched_if.expander ks
);
    import aes_pkg::*;

    logic            busy;                                   // Iterations still running
    logic            key_ready;
    logic [3:0]      rnd;                                    // Index of key being built
    logic [7:0]      rcon;
    aes_block_t      last_key;                               // Most recent round key
    aes_block_t      next_key;
    aes_round_keys_t rk;

    // One AES-128 schedule step, four words at a time
    function automatic aes_block_t expand_step(input aes_block_t prev, input logic [7:0] rc);
        logic [31:0] t;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        t  = {prev[23:0], prev[31:24]};                      // RotWord of last word
        t  = {sbox(t[31:24]), sbox(t[23:16]), sbox(t[15:8]), sbox(t[7:0])} ^ {rc, 24'h0};
        w0 = prev[127:96] ^ t;
        w1 = prev[95:64] ^ w0;
        w2 = prev[63:32] ^ w1;
        w3 = prev[31:0] ^ w2;
        return {w0, w1, w2, w3};
    endfunction

    assign next_key = expand_step(last_key, rcon);

    always_ff @(posedge slow_clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            key_ready <= 1'b0;
            rnd       <= '0;
            rcon      <= 8'h01;
        end else if (ks.start) begin
            busy      <= 1'b1;
            key_ready <= 1'b0;                               // New request drops old keys
            rnd       <= 4'd1;
            rcon      <= 8'h01;
        end else if (busy) begin
            rnd  <= rnd + 4'd1;
            rcon <= xtime(rcon);                             // 01 02 .. 80 1b 36
            if (rnd == 4'(`AES_NR)) begin
                busy      <= 1'b0;
                key_ready <= 1'b1;
            end
        end
    end

    // Key storage
    always_ff @(posedge slow_clk) begin
        if (ks.start) begin
            rk[0]    <= ks.key;
            last_key <= ks.key;
        end else if (busy) begin
            rk[rnd]  <= next_key;
            last_key <= next_key;
        end
    end

    assign ks.ready      = key_ready;
    assign ks.round_keys = rk;
endmodule

// ==== design/aes_enc_pipe.sv ====
`timescale 1ns/1ps
`include "aes_macros.svh"

module aes_enc_pipe (
    input  logic        slow_clk,
    input  logic        rst_n,
    key_sched_if.reader ks,
    block_stream_if.snk in_s,
    block_stream_if.src out_s
);
    import aes_pkg::*;
    import selftest_pkg::*;

    aes_block_t      st [0:`AES_NR];                         // Stage state registers
    vec_idx_t        tag [0:`AES_NR];
    logic [`AES_NR:0] vld;                                   // Bit n is stage n
    logic [`AES_NR:0] lst;

    function automatic aes_block_t enc_round(input aes_block_t s, input aes_block_t k,
                                             input logic final_rnd);
        aes_block_t t;
        t = shift_rows(sub_bytes(s, 1'b0), 1'b0);
        if (!final_rnd)
            t = mix_columns(t, 1'b0);                        // Skipped in round NR
        return t ^ k;
    endfunction

    // Blocks offered before keys are ready are dropped
    always_ff @(posedge slow_clk) begin
        if (!rst_n)
            vld <= '0;
        else
            vld <= {vld[`AES_NR-1:0], in_s.valid & ks.ready};
    end

    // ------------------------------
    // Datapath
    // ------------------------------
    always_ff @(posedge slow_clk) begin
        st[0]  <= in_s.data ^ ks.round_keys[0];              // Initial AddRoundKey
        tag[0] <= in_s.tag;
        lst    <= {lst[`AES_NR-1:0], in_s.last};
        for (int r = 1; r <= `AES_NR; r++) begin
            st[r]  <= enc_round(st[r-1], ks.round_keys[r], r == `AES_NR);
            tag[r] <= tag[r-1];
        end
    end

    assign out_s.valid = vld[`AES_NR];
    assign out_s.data  = st[`AES_NR];
    assign out_s.tag   = tag[`AES_NR];
    assign out_s.last  = lst[`AES_NR];
endmodule

// ==== design/aes_dec_pipe.sv ====
`timescale 1ns/1ps
`include "aes_macros.svh"

module aes_dec_pipe (
    input  logic        slow_clk,
    input  logic        rst_n,
    key_sched_if.reader ks,
    block_stream_if.snk in_s,
    block_stream_if.src out_s
);
    import aes_pkg::*;
    import selftest_pkg::*;

    aes_block_t      st [0:`AES_NR];
    vec_idx_t        tag [0:`AES_NR];
    logic [`AES_NR:0] vld;
    logic [`AES_NR:0] lst;

    // Inverse cipher round in the FIPS-197 InvCipher order
    function automatic aes_block_t dec_round(input aes_block_t s, input aes_block_t k,
                                             input logic final_rnd);
        aes_block_t t;
        t = sub_bytes(shift_rows(s, 1'b1), 1'b1) ^ k;
        if (!final_rnd)
            t = mix_columns(t, 1'b1);                        // No InvMixColumns at the end
        return t;
    endfunction

    always_ff @(posedge slow_clk) begin
        if (!rst_n)
            vld <= '0;
        else
            vld <= {vld[`AES_NR-1:0], in_s.valid & ks.ready};
    end

    // ------------------------------
    // Datapath, keys in reverse
    // ------------------------------
    always_ff @(posedge slow_clk) begin
        st[0]  <= in_s.data ^ ks.round_keys[`AES_NR];        // Start from the last key
        tag[0] <= in_s.tag;
        lst    <= {lst[`AES_NR-1:0], in_s.last};
        for (int r = 1; r <= `AES_NR; r++) begin
            st[r]  <= dec_round(st[r-1], ks.round_keys[`AES_NR - r], r == `AES_NR);
            tag[r] <= tag[r-1];
        end
    end

    // Recovered plaintext
    assign out_s.valid = vld[`AES_NR];
    assign out_s.data  = st[`AES_NR];
    assign out_s.tag   = tag[`AES_NR];
    assign out_s.last  = lst[`AES_NR];
endmodule

// ==== design/selftest_ctrl.sv ====
`timescale 1ns/1ps
`include "aes_macros.svh"

module selftest_ctrl (
    input  logic        slow_clk,
    input  logic        rst_n,
    input  logic        start,
    key_sched_if.ctrl   ks,
    block_stream_if.src feed,
    output logic        key_fail,
    output logic        idle,
    output logic        wait_key,
    output logic        feeding
);
    import selftest_pkg::*;

    localparam int WAIT_W = $clog2(`AES_KEY_TIMEOUT + 1);

    logic              start_meta;
    logic              start_sync;                           // Safe to use in the FSM
    selftest_state_t   state;
    vec_idx_t          feed_idx;
    logic [WAIT_W-1:0] wait_cnt;

    always_ff @(posedge slow_clk) begin
        if (!rst_n) begin
            start_meta <= 1'b0;
            start_sync <= 1'b0;
        end else begin
            start_meta <= start;
            start_sync <= start_meta;
        end
    end

    // ------------------------------
    // Sequencer
    // ------------------------------
    always_ff @(posedge slow_clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            feed_idx <= '0;
            wait_cnt <= '0;
            key_fail <= 1'b0;
        end else begin
            case (state)
                IDLE:     if (start_sync) state <= KEY_GEN;
                KEY_GEN: begin
                    wait_cnt <= '0;
                    state    <= WAIT_KEY;
                end
                WAIT_KEY: begin
                    if (ks.ready) begin
                        feed_idx <= '0;
                        state    <= FEED;
                    end else if (wait_cnt == WAIT_W'(`AES_KEY_TIMEOUT - 1)) begin
                        key_fail <= 1'b1;                    // Expander never finished
                        state    <= HALT;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                FEED: begin
                    if (feed_idx == vec_idx_t'(`AES_NUM_VECTORS - 1))
                        state <= HALT;
                    else
                        feed_idx <= feed_idx + 1'b1;
                end
                HALT:     state <= HALT;                     // Wait for reset
                default:  state <= IDLE;
            endcase
        end
    end

    assign ks.start = (state == KEY_GEN);                    // Single cycle by construction
    assign ks.key   = SELFTEST_KEY;

    assign feed.valid = (state == FEED);
    assign feed.data  = test_vector(feed_idx);
    assign feed.tag   = feed_idx;
    assign feed.last  = feeding && (feed_idx == vec_idx_t'(`AES_NUM_VECTORS - 1));

    assign idle     = (state == IDLE);
    assign wait_key = (state == KEY_GEN) || (state == WAIT_KEY);
    assign feeding  = (state == FEED);
endmodule

// ==== design/selftest_checker.sv ====
`timescale 1ns/1ps
`include "aes_macros.svh"

module selftest_checker (
    input  logic        slow_clk,
    input  logic        rst_n,
    block_stream_if.snk cipher,
    block_stream_if.snk plain,
    input  logic        key_fail,
    output logic        success,
    output logic        error,
    output logic        done
);
    import selftest_pkg::*;

    logic rt_mismatch;                                       // Round trip failed
    logic kat_mismatch;                                      // Known answer failed
    logic finish;

    // A tag outside the vector set counts as a mismatch
    assign rt_mismatch  = plain.valid &&
                          ((plain.tag >= vec_idx_t'(`AES_NUM_VECTORS)) ||
                           (plain.data != test_vector(plain.tag)));
    assign kat_mismatch = cipher.valid && (cipher.tag == '0) &&
                          (cipher.data != KAT_CIPHERTEXT);
    assign finish       = key_fail || (plain.valid && plain.last);

    always_ff @(posedge slow_clk) begin
        if (!rst_n) begin
            success <= 1'b0;
            error   <= 1'b0;
            done    <= 1'b0;
        end else if (!done) begin                            // Flags freeze once done
            if (rt_mismatch || kat_mismatch || key_fail)
                error <= 1'b1;
            if (finish) begin
                done    <= 1'b1;
                success <= !(error || rt_mismatch || kat_mismatch || key_fail);
            end
        end
    end
endmodule

// ==== design/aes_selftest_top.sv ====
`timescale 1ns/1ps

module aes_selftest_top (
    input  logic slow_clk,
    input  logic rst_n,
    input  logic start,
    output logic success,
    output logic error,
    output logic done,
    output logic idle,
    output logic wait_key,
    output logic feeding
);
    logic key_fail;                                          // Controller to checker

    key_sched_if    ks ();
    block_stream_if feed ();                                 // Plaintext into encryptor
    block_stream_if cipher ();
    block_stream_if plain ();                                // Decryptor output

    selftest_ctrl u_ctrl (
        .slow_clk (slow_clk),
        .rst_n    (rst_n),
        .start    (start),
        .ks       (ks.ctrl),
        .feed     (feed.src),
        .key_fail (key_fail),
        .idle     (idle),
        .wait_key (wait_key),
        .feeding  (feeding)
    );

    aes_key_expand u_key_expand (.slow_clk(slow_clk), .rst_n(rst_n), .ks(ks.expander));

    aes_enc_pipe u_enc (
        .slow_clk (slow_clk), .rst_n (rst_n), .ks (ks.reader),
        .in_s     (feed.snk), .out_s (cipher.src)
    );

    aes_dec_pipe u_dec (
        .slow_clk (slow_clk), .rst_n (rst_n), .ks (ks.reader),
        .in_s     (cipher.snk), .out_s (plain.src)
    );

    selftest_checker u_checker (
        .slow_clk (slow_clk),
        .rst_n    (rst_n),
        .cipher   (cipher.snk),
        .plain    (plain.snk),
        .key_fail (key_fail),
        .success  (success),
        .error    (error),
        .done     (done)
    );
endmodule

// ==== testbench/tb_aes_selftest.sv ====
`timescale 1ns/1ps
`include "aes_macros.svh"

module tb_aes_selftest;

    localparam int CLK_PERIOD      = 8;                      // ns
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;                    // Watchdog budget per test
    localparam int WAIT_KEY_LIMIT  = 4;                      // Start pulse to wait_key
    localparam int DONE_LIMIT      = 60;                     // Start pulse to done

    logic slow_clk;
    logic rst_n;
    logic start;
    logic success;
    logic error;
    logic done;
    logic idle;
    logic wait_key;
    logic feeding;

    int          value_errors;                               // Wrong output values
    int          other_errors;                               // Timeouts
    int          last_gap;
    time         start_time;                                 // Edge where start was raised

    aes_selftest_top UUT (
        .slow_clk (slow_clk),
        .rst_n    (rst_n),
        .start    (start),
        .success  (success),
        .error    (error),
        .done     (done),
        .idle     (idle),
        .wait_key (wait_key),
        .feeding  (feeding)
    );

    always #(CLK_PERIOD / 2) slow_clk = ~slow_clk;

    // Hard stop if a wait loop never returns
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired: the tests did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected %b got %b", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // Order is success, error, done, idle, wait_key, feeding
    task automatic check_status(input logic [5:0] expected);
        compare_bit("success", expected[5], success);
        compare_bit("error", expected[4], error);
        compare_bit("done", expected[3], done);
        compare_bit("idle", expected[2], idle);
        compare_bit("wait_key", expected[1], wait_key);
        compare_bit("feeding", expected[0], feeding);
    endtask

    task automatic check_state_flags(input logic [2:0] expected);   // idle, wait_key, feeding
        compare_bit("idle", expected[2], idle);
        compare_bit("wait_key", expected[1], wait_key);
        compare_bit("feeding", expected[0], feeding);
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    function automatic logic output_bit(input string name);
        if (name == "done")
            return done;
        else if (name == "feeding")
            return feeding;
        else if (name == "wait_key")
            return wait_key;
        return idle;
    endfunction

    // Polls one output on falling edges until it reaches the level
    task automatic wait_output(input string name, input logic level, input int max_cycles,
                               output bit ok);
        int n;
        n  = 0;
        ok = 1'b1;
        @(negedge slow_clk);
        while (output_bit(name) !== level && n < max_cycles) begin
            @(negedge slow_clk);
            n++;
        end
        if (output_bit(name) !== level) begin
            $display("Timeout at %0t: %s did not go to %b within %0d cycles",
                     $time, name, level, max_cycles);
            other_errors++;
            ok = 1'b0;
        end
    endtask

    task automatic apply_reset();
        @(posedge slow_clk);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge slow_clk);
        rst_n <= 1'b1;
    endtask

    task automatic pick_gap(output int gap);
        do
            gap = 1 + int'($urandom % 16);                   // 1 to 16 idle cycles
        while (gap == last_gap);
        last_gap = gap;
    endtask

    task automatic pulse_start();
        @(posedge slow_clk);
        start      <= 1'b1;
        start_time  = $time;
        @(posedge slow_clk);
        start <= 1'b0;                                       // One cycle wide
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_reset_state();
        int gap;
        apply_reset();
        pick_gap(gap);
        repeat (gap) begin
            @(negedge slow_clk);
            check_status(6'b000100);                         // Only idle high
        end
    endtask

    task automatic test_start_sequence();
        int n;
        bit ok;
        pulse_start();
        wait_output("wait_key", 1'b1, WAIT_KEY_LIMIT, ok);
        if (ok)
            check_state_flags(3'b010);
        wait_output("feeding", 1'b1, `AES_KEY_TIMEOUT + 4, ok);
        n = 0;
        if (ok) begin
            check_state_flags(3'b001);                       // wait_key already dropped
            while (feeding === 1'b1 && n <= 2 * `AES_NUM_VECTORS) begin
                n++;
                @(negedge slow_clk);
            end
            check_count("feeding cycles", `AES_NUM_VECTORS, n);
            check_state_flags(3'b000);                       // Halted
        end
    endtask

    task automatic test_selftest_pass();
        int elapsed;
        bit ok;
        elapsed = int'(($time - start_time) / CLK_PERIOD);
        wait_output("done", 1'b1, DONE_LIMIT - elapsed, ok);
        check_status(6'b101000);                             // success and done only
    endtask

    task automatic test_halt_holds();
        repeat (3) begin
            pulse_start();
            repeat (2 * WAIT_KEY_LIMIT) begin                // Past the synchronizer delay
                @(negedge slow_clk);
                check_status(6'b101000);
            end
        end
    endtask

    task automatic test_rerun();
        test_reset_state();
        test_start_sequence();
        test_selftest_pass();
    endtask

    task automatic test_start_during_reset();
        @(posedge slow_clk);
        rst_n <= 1'b0;
        start <= 1'b1;                                       // Held through reset
        repeat (RESET_CYCLES) @(posedge slow_clk);
        start <= 1'b0;
        @(negedge slow_clk);
        check_status(6'b000100);
        @(posedge slow_clk);
        rst_n <= 1'b1;
        repeat (2 * `AES_NUM_VECTORS) begin
            @(negedge slow_clk);
            check_status(6'b000100);                         // Must stay idle
        end
    endtask

    initial begin
        slow_clk     = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        value_errors = 0;
        other_errors = 0;
        last_gap     = -1;
        void'($urandom(86));                                 // Seeds the generator
        test_reset_state();
        test_start_sequence();
        test_selftest_pass();
        test_halt_holds();
        test_rerun();
        test_start_during_reset();
        $display("Error count: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end
endmodule

// ==== verilog.f ====
+incdir+design
design/aes_pkg.sv
design/selftest_pkg.sv
design/aes_ifs.sv
design/aes_key_expand.sv
design/aes_enc_pipe.sv
design/aes_dec_pipe.sv
design/selftest_ctrl.sv
design/selftest_checker.sv
design/aes_selftest_top.sv
testbench/tb_aes_selftest.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AES self-test testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_aes_selftest -f verilog.f \
    -o tb_aes_selftest && ./obj_dir/tb_aes_selftest > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
